// ==== bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// branch address width
`define BP_ADDR_WIDTH 32

// global and local history length, also the pattern table index width
`define BP_HISTORY_DEPTH 8

`define BP_BHT_INDEX_BITS 6      // local history table, pc[7:2]
`define BP_CHOOSER_INDEX_BITS 6  // chooser table, pc[7:2]

// width of the resolve and correct-prediction counters
`define BP_PERF_WIDTH 16

`endif

// ==== bp_pkg.sv ====
`default_nettype none

`include "bp_params.svh"

package bp_pkg;

    // two-bit saturating counter, msb set means taken
    typedef enum logic [1:0] {
        strongly_nt = 2'b00,
        weakly_nt   = 2'b01,
        weakly_t    = 2'b10,
        strongly_t  = 2'b11
    } ctr_state_t;

    // chooser msb picks the source
    typedef enum logic {
        local_pred  = 1'b0,
        global_pred = 1'b1
    } pred_src_t;

    // shift register of past outcomes, newest at bit 0
    typedef logic [`BP_HISTORY_DEPTH-1:0] history_t;

endpackage

`default_nettype wire

// ==== history_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module history_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`BP_ADDR_WIDTH-1:0] lookup_pc,
    input  logic [`BP_ADDR_WIDTH-1:0] resolve_pc,
    input  logic                      shift_en,
    input  logic                      taken,
    output bp_pkg::history_t          global_hist,
    output bp_pkg::history_t          lookup_local_hist,
    output bp_pkg::history_t          resolve_local_hist
);
    import bp_pkg::*;

    localparam int BHT_ENTRIES = 2 ** `BP_BHT_INDEX_BITS;

    history_t global_q;                         // ghr
    history_t local_q [BHT_ENTRIES];            // bht, one history per pc slot

    logic [`BP_BHT_INDEX_BITS-1:0] lookup_idx;
    logic [`BP_BHT_INDEX_BITS-1:0] resolve_idx;

    // word aligned pcs, skip the low two bits
    assign lookup_idx  = lookup_pc[`BP_BHT_INDEX_BITS+1:2];
    assign resolve_idx = resolve_pc[`BP_BHT_INDEX_BITS+1:2];

    assign global_hist        = global_q;
    assign lookup_local_hist  = local_q[lookup_idx];
    assign resolve_local_hist = local_q[resolve_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            global_q <= '0;
        end else if (shift_en) begin
            global_q <= {global_q[`BP_HISTORY_DEPTH-2:0], taken};   // newest outcome at bit 0
        end
    end

    // same shift for the resolving branch's own history
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                local_q[i] <= '0;
            end
        end else if (shift_en) begin
            local_q[resolve_idx] <= {resolve_local_hist[`BP_HISTORY_DEPTH-2:0], taken};
        end
    end

endmodule : history_unit

`default_nettype wire

// ==== perf_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module perf_counter #(
    parameter int WIDTH = `BP_PERF_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             count,
    output logic [WIDTH-1:0] value
);

    logic [WIDTH-1:0] incr;

    assign incr = {{(WIDTH-1){1'b0}}, count};   // zero or one

    // wraps silently at 2**WIDTH
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else begin
            value <= value + incr;
        end
    end

endmodule : perf_counter

`default_nettype wire

// ==== project.f ====
+incdir+.
bp_pkg.sv
sat_counter_table.sv
history_unit.sv
perf_counter.sv
tournament_predictor.sv
tb_tournament_predictor_assertions.sv
tb_tournament_predictor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the tournament predictor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_tournament_predictor \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// ==== sat_counter_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module sat_counter_table #(
    parameter int INDEX_BITS = `BP_HISTORY_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_BITS-1:0] lookup_index,
    input  logic [INDEX_BITS-1:0] train_index,
    output bp_pkg::ctr_state_t    lookup_state,
    output bp_pkg::ctr_state_t    train_state,
    input  logic                  inc,
    input  logic                  dec
);
    import bp_pkg::*;

    localparam int ENTRIES = 2 ** INDEX_BITS;

    ctr_state_t counters [ENTRIES];
    ctr_state_t train_next;

    // both reads see the table before this edge's update
    assign lookup_state = counters[lookup_index];
    assign train_state  = counters[train_index];

    always_comb begin
        train_next = train_state;                               // hold by default
        if (inc && train_state != strongly_t) begin
            train_next = ctr_state_t'(train_state + 2'd1);      // step toward taken
        end else if (dec && train_state != strongly_nt) begin
            train_next = ctr_state_t'(train_state - 2'd1);      // step toward not taken
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= weakly_nt;
            end
        end else if (inc || dec) begin
            counters[train_index] <= train_next;
        end
    end

endmodule : sat_counter_table

`default_nettype wire

// ==== tb_tournament_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tb_tournament_predictor;
    import bp_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int TRAIN_STEPS    = 12;
    localparam int RANDOM_CYCLES  = 400;
    localparam int CHOOSER_ROUNDS = 60;
    localparam int TOTAL_CYCLES   = 2 + 8 + 2 * (TRAIN_STEPS + 1) + RANDOM_CYCLES
                                    + 2 * CHOOSER_ROUNDS + 4;

    logic                      clk;
    logic                      rst;
    logic                      lookup_valid;
    logic [`BP_ADDR_WIDTH-1:0] lookup_pc;
    logic                      resolve_valid;
    logic                      resolve_taken;
    logic [`BP_ADDR_WIDTH-1:0] resolve_pc;
    logic                      pred_valid;
    logic                      pred_taken;
    logic [`BP_PERF_WIDTH-1:0] num_branches;
    logic [`BP_PERF_WIDTH-1:0] num_correct;

    // reference model state
    history_t                  m_ghr;
    history_t                  m_local_hist [64];
    ctr_state_t                m_global_pht [256];
    ctr_state_t                m_local_pht [256];
    ctr_state_t                m_chooser [64];
    logic [`BP_PERF_WIDTH-1:0] m_branches;
    logic [`BP_PERF_WIDTH-1:0] m_correct;

    logic [31:0] lfsr_state = 32'he94a44dc;
    string       test_name = "after_reset";
    int          errors = 0;

    tournament_predictor u_dut (
        .clk(clk),
        .rst(rst),
        .lookup_valid(lookup_valid),
        .lookup_pc(lookup_pc),
        .pred_valid(pred_valid),
        .pred_taken(pred_taken),
        .resolve_valid(resolve_valid),
        .resolve_taken(resolve_taken),
        .resolve_pc(resolve_pc),
        .num_branches(num_branches),
        .num_correct(num_correct)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit, newest bit lands at bit 0
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [31:0] pc_from_slot(input logic [5:0] slot);
        return {24'h000010, slot, 2'b00};
    endfunction

    function automatic ctr_state_t step_toward(input ctr_state_t s, input logic up);
        ctr_state_t n;
        case (s)
            strongly_nt: n = up ? weakly_nt : strongly_nt;
            weakly_nt:   n = up ? weakly_t : strongly_nt;
            weakly_t:    n = up ? strongly_t : weakly_nt;
            default:     n = up ? strongly_t : weakly_t;
        endcase
        return n;
    endfunction

    function automatic logic model_predict(input logic [31:0] pc);
        ctr_state_t loc;
        ctr_state_t glob;
        loc  = m_local_pht[m_local_hist[pc[7:2]]];
        glob = m_global_pht[m_ghr];
        return m_chooser[pc[7:2]][1] ? glob[1] : loc[1];   // chooser msb picks global
    endfunction

    task automatic model_reset();
        m_ghr = '0;
        m_branches = '0;
        m_correct = '0;
        for (int i = 0; i < 64; i++) begin
            m_local_hist[i] = '0;
            m_chooser[i] = weakly_nt;
        end
        for (int i = 0; i < 256; i++) begin
            m_global_pht[i] = weakly_nt;
            m_local_pht[i] = weakly_nt;
        end
    endtask

    task automatic model_resolve(input logic [31:0] pc, input logic taken);
        logic [5:0] slot;
        history_t   lh;
        logic       glob_ok;
        logic       loc_ok;
        logic       pred;
        slot = pc[7:2];
        lh = m_local_hist[slot];
        pred = model_predict(pc);
        glob_ok = (m_global_pht[m_ghr][1] == taken);
        loc_ok = (m_local_pht[lh][1] == taken);
        if (glob_ok && !loc_ok) begin
            m_chooser[slot] = step_toward(m_chooser[slot], 1'b1);
        end else if (loc_ok && !glob_ok) begin
            m_chooser[slot] = step_toward(m_chooser[slot], 1'b0);
        end
        m_global_pht[m_ghr] = step_toward(m_global_pht[m_ghr], taken);
        m_local_pht[lh] = step_toward(m_local_pht[lh], taken);
        m_ghr = {m_ghr[`BP_HISTORY_DEPTH-2:0], taken};
        m_local_hist[slot] = {lh[`BP_HISTORY_DEPTH-2:0], taken};
        m_branches = m_branches + 16'd1;
        if (pred == taken) begin
            m_correct = m_correct + 16'd1;
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // called at the drive point, returns at the next one
    task automatic run_cycle(input logic lv, input logic [31:0] lpc, input logic rv,
                             input logic [31:0] rpc, input logic rt);
        logic exp_pred;
        lookup_valid = lv;
        lookup_pc = lpc;
        resolve_valid = rv;
        resolve_pc = rpc;
        resolve_taken = rt;
        exp_pred = model_predict(lpc);      // tables before this edge
        if (rv) begin
            model_resolve(rpc, rt);
        end
        @(posedge clk);
        #1;
        check_bit("pred_valid", lv, pred_valid);
        if (lv) begin
            check_bit("pred_taken", exp_pred, pred_taken);
        end
        check_count("num_branches", m_branches, num_branches);
        check_count("num_correct", m_correct, num_correct);
    endtask

    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog timeout: the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] bits;
        logic [31:0] lpc;
        logic [31:0] rpc;
        logic [31:0] pc_a;
        logic        lv;
        logic        rv;
        logic        rt;
        ctr_state_t  prev;
        int          moves;
        int          total;
        clk = 1'b0;
        rst = 1'b1;
        lookup_valid = 1'b0;
        lookup_pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        moves = 0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_bit("pred_valid", 1'b0, pred_valid);
        check_count("num_branches", 16'd0, num_branches);
        check_count("num_correct", 16'd0, num_correct);
        for (int i = 0; i < 4; i++) begin
            run_cycle(1'b1, pc_from_slot(6'(i * 9)), 1'b0, 32'h0, 1'b0);
            check_bit("first_lookup", 1'b0, pred_taken);
        end
        run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);

        test_name = "training";
        pc_a = pc_from_slot(6'd16);
        for (int i = 0; i < TRAIN_STEPS; i++) begin
            run_cycle(1'b1, pc_a, 1'b1, pc_a, 1'b1);
        end
        run_cycle(1'b1, pc_a, 1'b0, 32'h0, 1'b0);
        check_bit("trained_taken", 1'b1, pred_taken);
        for (int i = 0; i < TRAIN_STEPS; i++) begin
            run_cycle(1'b1, pc_a, 1'b1, pc_a, 1'b0);
        end
        run_cycle(1'b1, pc_a, 1'b0, 32'h0, 1'b0);
        check_bit("trained_not_taken", 1'b0, pred_taken);

        test_name = "random_stream";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            take_bits(4, bits);
            lpc = pc_from_slot({2'b00, bits[3:0]});     // 16 pcs, plenty of repeats
            take_bits(3, bits);
            lv = bits[2];
            rv = bits[1];
            rt = bits[0];
            take_bits(1, bits);
            if (bits[0]) begin
                rpc = lpc;
            end else begin
                take_bits(4, bits);
                rpc = pc_from_slot({2'b00, bits[3:0]});
            end
            run_cycle(lv, lpc, rv, rpc, rt);
        end

        // alternating branch plus a noisy neighbor feeding the ghr
        test_name = "chooser_switch";
        pc_a = pc_from_slot(6'd32);
        for (int i = 0; i < CHOOSER_ROUNDS; i++) begin
            prev = m_chooser[32];
            run_cycle(1'b1, pc_a, 1'b1, pc_a, i[0]);
            if (m_chooser[32] != prev) begin
                moves++;
            end
            take_bits(1, bits);
            run_cycle(1'b1, pc_from_slot(6'd33), 1'b1, pc_from_slot(6'd33), bits[0]);
        end
        assert (moves > 0) else begin
            $display("chooser entry of the alternating branch never moved");
            errors++;
        end

        repeat (3) run_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0);

        total = errors + u_dut.u_assertions.fail_count;
        $display("errors: %0d value checks, %0d protocol assertions",
                 errors, u_dut.u_assertions.fail_count);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_tournament_predictor

`default_nettype wire

// ==== tb_tournament_predictor_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tb_tournament_predictor_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      lookup_valid,
    input logic                      pred_valid,
    input logic                      resolve_valid,
    input logic [`BP_PERF_WIDTH-1:0] num_branches,
    input logic [`BP_PERF_WIDTH-1:0] num_correct
);

    localparam logic [`BP_PERF_WIDTH-1:0] COUNT_STEP = 1;

    int fail_count = 0;     // read by the testbench at the end of the run

    // every lookup gets its prediction on the next cycle
    a_pred_follows_lookup: assert property (@(posedge clk) disable iff (rst)
        lookup_valid |=> pred_valid)
    else begin
        fail_count++;
        $error("pred_valid missing one cycle after a lookup strobe");
    end

    a_no_spurious_pred: assert property (@(posedge clk) disable iff (rst)
        !lookup_valid |=> !pred_valid)
    else begin
        fail_count++;
        $error("pred_valid raised without a lookup strobe");
    end

    a_branch_count_step: assert property (@(posedge clk) disable iff (rst)
        resolve_valid |=> (num_branches == $past(num_branches) + COUNT_STEP))
    else begin
        fail_count++;
        $error("num_branches did not step by one after a resolve");
    end

    a_branch_count_hold: assert property (@(posedge clk) disable iff (rst)
        !resolve_valid |=> $stable(num_branches))
    else begin
        fail_count++;
        $error("num_branches changed without a resolve");
    end

    // correct count only moves on a resolve
    a_correct_needs_resolve: assert property (@(posedge clk) disable iff (rst)
        !resolve_valid |=> $stable(num_correct))
    else begin
        fail_count++;
        $error("num_correct changed without a resolve");
    end

endmodule : tb_tournament_predictor_assertions

bind tournament_predictor tb_tournament_predictor_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .lookup_valid(lookup_valid),
    .pred_valid(pred_valid),
    .resolve_valid(resolve_valid),
    .num_branches(num_branches),
    .num_correct(num_correct)
);

`default_nettype wire

// ==== tournament_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tournament_predictor (
    input  logic                      clk,
    input  logic                      rst,

    // lookup side
    input  logic                      lookup_valid,
    input  logic [`BP_ADDR_WIDTH-1:0] lookup_pc,
    output logic                      pred_valid,
    output logic                      pred_taken,

    // resolve side
    input  logic                      resolve_valid,
    input  logic                      resolve_taken,
    input  logic [`BP_ADDR_WIDTH-1:0] resolve_pc,

    // perf counters
    output logic [`BP_PERF_WIDTH-1:0] num_branches,
    output logic [`BP_PERF_WIDTH-1:0] num_correct
);
    import bp_pkg::*;

    history_t global_hist;
    history_t lookup_local_hist;
    history_t resolve_local_hist;

    ctr_state_t lu_global_state;
    ctr_state_t lu_local_state;
    ctr_state_t lu_chooser_state;
    ctr_state_t rs_global_state;
    ctr_state_t rs_local_state;
    ctr_state_t rs_chooser_state;

    pred_src_t lu_src;
    pred_src_t rs_src;

    logic lu_pred;
    logic rs_pred;
    logic global_correct;
    logic local_correct;
    logic pht_inc;
    logic pht_dec;
    logic chooser_inc;
    logic chooser_dec;
    logic correct_count;

    // tournament mux, counter msb of the chosen table
    function automatic logic pick_pred(pred_src_t src, ctr_state_t local_st,
                                       ctr_state_t global_st);
        logic taken;
        unique case (src)
            local_pred:  taken = local_st[1];
            global_pred: taken = global_st[1];
            default:     taken = 1'b0;
        endcase
        return taken;
    endfunction

    history_unit u_history (
        .clk(clk),
        .rst(rst),
        .lookup_pc(lookup_pc),
        .resolve_pc(resolve_pc),
        .shift_en(resolve_valid),
        .taken(resolve_taken),
        .global_hist(global_hist),
        .lookup_local_hist(lookup_local_hist),
        .resolve_local_hist(resolve_local_hist)
    );

    sat_counter_table #(.INDEX_BITS(`BP_HISTORY_DEPTH)) u_global_pht (
        .clk(clk),
        .rst(rst),
        .lookup_index(global_hist),
        .train_index(global_hist),          // one ghr serves both sides
        .lookup_state(lu_global_state),
        .train_state(rs_global_state),
        .inc(pht_inc),
        .dec(pht_dec)
    );

    sat_counter_table #(.INDEX_BITS(`BP_HISTORY_DEPTH)) u_local_pht (
        .clk(clk),
        .rst(rst),
        .lookup_index(lookup_local_hist),
        .train_index(resolve_local_hist),
        .lookup_state(lu_local_state),
        .train_state(rs_local_state),
        .inc(pht_inc),
        .dec(pht_dec)
    );

    sat_counter_table #(.INDEX_BITS(`BP_CHOOSER_INDEX_BITS)) u_chooser (
        .clk(clk),
        .rst(rst),
        .lookup_index(lookup_pc[`BP_CHOOSER_INDEX_BITS+1:2]),
        .train_index(resolve_pc[`BP_CHOOSER_INDEX_BITS+1:2]),
        .lookup_state(lu_chooser_state),
        .train_state(rs_chooser_state),
        .inc(chooser_inc),
        .dec(chooser_dec)
    );

    // lookup prediction
    assign lu_src  = pred_src_t'(lu_chooser_state[1]);
    assign lu_pred = pick_pred(lu_src, lu_local_state, lu_global_state);

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
            if (lookup_valid) begin
                pred_taken <= lu_pred;          // holds between lookups
            end
        end
    end

    // resolve side, all from pre-update tables
    assign rs_src         = pred_src_t'(rs_chooser_state[1]);
    assign rs_pred        = pick_pred(rs_src, rs_local_state, rs_global_state);
    assign global_correct = (rs_global_state[1] == resolve_taken);
    assign local_correct  = (rs_local_state[1] == resolve_taken);

    // both pattern tables follow the outcome
    assign pht_inc = resolve_valid && resolve_taken;
    assign pht_dec = resolve_valid && !resolve_taken;

    // chooser leans toward whichever table alone got it right
    assign chooser_inc = resolve_valid && global_correct && !local_correct;
    assign chooser_dec = resolve_valid && local_correct && !global_correct;

    assign correct_count = resolve_valid && (rs_pred == resolve_taken);

    perf_counter #(.WIDTH(`BP_PERF_WIDTH)) u_branch_count (
        .clk(clk),
        .rst(rst),
        .count(resolve_valid),
        .value(num_branches)
    );

    perf_counter #(.WIDTH(`BP_PERF_WIDTH)) u_correct_count (
        .clk(clk),
        .rst(rst),
        .count(correct_count),
        .value(num_correct)
    );

endmodule : tournament_predictor

`default_nettype wire
